//--- include/bft_cnfg_config.svh
`ifndef BFT_CNFG_CONFIG_SVH
`define BFT_CNFG_CONFIG_SVH

// ------------------------------
// bus geometry
// ------------------------------
`define CNFG_DATA_BITS 64   // axi-lite data width
`define CNFG_STRB_BITS 8    // one strobe per byte
`define CNFG_N_REGS    32   // register slots
`define CNFG_ADDR_BITS 8    // [7:3] index, [2:0] byte offset

// ------------------------------
// register map
// ------------------------------
`define CNFG_REG_CONTROL         5'd0   // write only, bit 0 = ap_clr
`define CNFG_REG_OPEN_CON        5'd2
`define CNFG_REG_OPEN_PORT       5'd3
`define CNFG_REG_CLOSE_CON       5'd4
`define CNFG_REG_OPEN_STATUS     5'd5   // pops conn status stream
`define CNFG_REG_PORT_STATUS     5'd6   // pops port status stream
`define CNFG_REG_CONS_BYTES_NET  5'd7
`define CNFG_REG_PROD_BYTES_NET  5'd8
`define CNFG_REG_MAX_PKG_WORD    5'd11
`define CNFG_REG_CONS_BYTES_HOST 5'd12
`define CNFG_REG_PROD_BYTES_HOST 5'd13
`define CNFG_REG_BATCH_MAX_TIMER 5'd25
`define CNFG_REG_BUFF_CMD        5'd31

`endif

//--- rtl/bft_cnfg_pkg.sv
`default_nettype none

`include "bft_cnfg_config.svh"

package bft_cnfg_pkg;

  typedef logic [$clog2(`CNFG_N_REGS)-1:0] reg_idx_t;
  typedef logic [`CNFG_DATA_BITS-1:0]      cnfg_word_t;

  // ------------------------------
  // axi-lite channels
  // ------------------------------
  typedef struct packed {
    logic                       awvalid;
    logic [`CNFG_ADDR_BITS-1:0] awaddr;
    logic                       wvalid;
    cnfg_word_t                 wdata;
    logic [`CNFG_STRB_BITS-1:0] wstrb;
    logic                       bready;
    logic                       arvalid;
    logic [`CNFG_ADDR_BITS-1:0] araddr;
    logic                       rready;
  } axil_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
    logic       arready;
    logic       rvalid;
    cnfg_word_t rdata;
    logic [1:0] rresp;
  } axil_rsp_t;

  typedef struct packed {
    reg_idx_t                   idx;
    cnfg_word_t                 data;
    logic [`CNFG_STRB_BITS-1:0] strb;
  } wr_req_t;

  // ------------------------------
  // command and status words
  // ------------------------------
  typedef struct packed {
    logic [15:0] pad;
    logic [15:0] port;
    logic [31:0] ip;
  } conn_cmd_t;

  typedef struct packed {
    logic [15:0] size_kb;
    logic [47:0] base_offset;
  } buff_cmd_t;

  // same stored word, seen by the connection or the buffer engine
  typedef union packed {
    cnfg_word_t word;
    conn_cmd_t  conn;
    buff_cmd_t  buff;
  } cmd_word_u;

  typedef struct packed {
    logic [55:0] pad;
    logic [15:0] port;
    logic [31:0] ip;
    logic [7:0]  success;
    logic [15:0] session;
  } conn_sts_t;

  typedef struct packed {
    logic [15:0] port;
    logic [31:0] ip;
    logic        success;
    logic [14:0] session;
  } conn_sts_rd_t;

  typedef struct packed {
    cnfg_word_t cons_bytes_net;
    cnfg_word_t prod_bytes_net;
    cnfg_word_t cons_bytes_host;
    cnfg_word_t prod_bytes_host;
  } byte_counters_t;

endpackage

`default_nettype wire

//--- rtl/axil_wr_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "bft_cnfg_config.svh"

module axil_wr_channel (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  bft_cnfg_pkg::axil_req_t axil_req,
  output logic                    awready,
  output logic                    wready,
  output logic                    bvalid,
  output logic                    wr_valid,
  output bft_cnfg_pkg::wr_req_t   wr_req
);
  import bft_cnfg_pkg::*;

  localparam int IDX_LSB = $clog2(`CNFG_STRB_BITS);

  logic     wr_busy; // write outstanding until b handshake
  reg_idx_t aw_idx;

  // ------------------------------
  // address and data acceptance
  // ------------------------------
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      wr_busy <= 1'b0;
      aw_idx  <= '0;
    end else if (axil_req.awvalid && axil_req.wvalid && !wr_busy) begin
      awready <= 1'b1; // both ready for one cycle
      wready  <= 1'b1;
      wr_busy <= 1'b1;
      aw_idx  <= axil_req.awaddr[`CNFG_ADDR_BITS-1:IDX_LSB];
    end else begin
      awready <= 1'b0;
      wready  <= 1'b0;
      if (bvalid && axil_req.bready) begin
        wr_busy <= 1'b0; // response taken, open for next write
      end
    end
  end

  assign wr_valid = awready && wready && axil_req.awvalid && axil_req.wvalid;

  // data is still on the bus during the ready cycle
  assign wr_req = '{idx: aw_idx, data: axil_req.wdata, strb: axil_req.wstrb};

  // ------------------------------
  // write response
  // ------------------------------
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      bvalid <= 1'b0;
    end else if (wr_valid) begin
      bvalid <= 1'b1;
    end else if (axil_req.bready) begin
      bvalid <= 1'b0;
    end
  end

  a_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    bvalid && !axil_req.bready |=> bvalid)
    else $error("bvalid dropped before bready");

endmodule

`default_nettype wire

//--- rtl/axil_rd_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "bft_cnfg_config.svh"

module axil_rd_channel (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  bft_cnfg_pkg::axil_req_t axil_req,
  output logic                    arready,
  output logic                    rvalid,
  output logic                    rd_valid,
  output bft_cnfg_pkg::reg_idx_t  rd_idx
);

  localparam int IDX_LSB = $clog2(`CNFG_STRB_BITS);

  // address accepted only with no response pending
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      arready <= 1'b0;
      rd_idx  <= '0;
    end else if (axil_req.arvalid && !arready && !rvalid) begin
      arready <= 1'b1;
      rd_idx  <= axil_req.araddr[`CNFG_ADDR_BITS-1:IDX_LSB];
    end else begin
      arready <= 1'b0;
    end
  end

  assign rd_valid = arready && axil_req.arvalid; // read data latched on this edge

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      rvalid <= 1'b0;
    end else if (rd_valid) begin
      rvalid <= 1'b1;
    end else if (axil_req.rready) begin
      rvalid <= 1'b0;
    end
  end

  // a new address must wait until the previous response is taken
  a_no_ar_while_r: assert property (@(posedge aclk) disable iff (!aresetn)
    rvalid && !axil_req.rready |=> !arready)
    else $error("arready raised with read response pending");

endmodule

`default_nettype wire

//--- rtl/cnfg_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "bft_cnfg_config.svh"

module cnfg_reg_file (
  input  logic                     aclk,
  input  logic                     aresetn,
  input  logic                     wr_valid,
  input  bft_cnfg_pkg::wr_req_t    wr_req,
  output logic                     ap_clr,
  output bft_cnfg_pkg::cmd_word_u  open_con_cmd_tdata,
  output logic                     open_con_cmd_tvalid,
  output logic [31:0]              open_port_cmd_tdata,
  output logic                     open_port_cmd_tvalid,
  output logic [31:0]              close_con_cmd_tdata,
  output logic                     close_con_cmd_tvalid,
  output bft_cnfg_pkg::cmd_word_u  buff_cmd_tdata,
  output logic                     buff_cmd_tvalid,
  output bft_cnfg_pkg::cnfg_word_t max_pkg_word,
  output bft_cnfg_pkg::cnfg_word_t batch_max_timer
);
  import bft_cnfg_pkg::*;

  cnfg_word_t open_port_q;
  cnfg_word_t close_con_q;
  logic       wr_any;      // at least one byte strobed

  // byte-strobe merge into the stored word
  function automatic cnfg_word_t merge(input cnfg_word_t old_word,
                                       input cnfg_word_t new_word,
                                       input logic [`CNFG_STRB_BITS-1:0] strb);
    cnfg_word_t res;
    res = old_word;
    for (int i = 0; i < `CNFG_STRB_BITS; i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return res;
  endfunction

  assign wr_any = |wr_req.strb;

  // ------------------------------
  // register writes and pulses
  // ------------------------------
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      ap_clr               <= 1'b0;
      open_con_cmd_tdata   <= '0;
      open_port_q          <= '0;
      close_con_q          <= '0;
      buff_cmd_tdata       <= '0;
      max_pkg_word         <= '0;
      batch_max_timer      <= '0;
      open_con_cmd_tvalid  <= 1'b0;
      open_port_cmd_tvalid <= 1'b0;
      close_con_cmd_tvalid <= 1'b0;
      buff_cmd_tvalid      <= 1'b0;
    end else begin
      ap_clr               <= 1'b0; // self clearing
      open_con_cmd_tvalid  <= 1'b0;
      open_port_cmd_tvalid <= 1'b0;
      close_con_cmd_tvalid <= 1'b0;
      buff_cmd_tvalid      <= 1'b0;
      if (wr_valid) begin
        case (wr_req.idx)
          `CNFG_REG_CONTROL: begin
            if (wr_req.strb[0]) begin
              ap_clr <= wr_req.data[0]; // only byte 0 is writable
            end
          end
          `CNFG_REG_OPEN_CON: begin
            open_con_cmd_tdata.word <= merge(open_con_cmd_tdata.word, wr_req.data,
                                             wr_req.strb);
            open_con_cmd_tvalid     <= wr_any;
          end
          `CNFG_REG_OPEN_PORT: begin
            open_port_q          <= merge(open_port_q, wr_req.data, wr_req.strb);
            open_port_cmd_tvalid <= wr_any;
          end
          `CNFG_REG_CLOSE_CON: begin
            close_con_q          <= merge(close_con_q, wr_req.data, wr_req.strb);
            close_con_cmd_tvalid <= wr_any;
          end
          `CNFG_REG_BUFF_CMD: begin
            buff_cmd_tdata.word <= merge(buff_cmd_tdata.word, wr_req.data, wr_req.strb);
            buff_cmd_tvalid     <= wr_any;
          end
          `CNFG_REG_MAX_PKG_WORD: max_pkg_word <= merge(max_pkg_word, wr_req.data,
                                                        wr_req.strb);
          `CNFG_REG_BATCH_MAX_TIMER: batch_max_timer <= merge(batch_max_timer,
                                                              wr_req.data, wr_req.strb);
          default: ; // read-only or unmapped
        endcase
      end
    end
  end

  assign open_port_cmd_tdata = open_port_q[31:0]; // port cmd is 32 bits wide
  assign close_con_cmd_tdata = close_con_q[31:0];

  a_one_cmd: assert property (@(posedge aclk) disable iff (!aresetn)
    $onehot0({open_con_cmd_tvalid, open_port_cmd_tvalid,
              close_con_cmd_tvalid, buff_cmd_tvalid}))
    else $error("more than one command valid in a cycle");

endmodule

`default_nettype wire

//--- rtl/cnfg_status_reader.sv
`timescale 1ns/1ps
`default_nettype none

`include "bft_cnfg_config.svh"

module cnfg_status_reader (
  input  logic                         aclk,
  input  logic                         aresetn,
  input  logic                         rd_valid,
  input  bft_cnfg_pkg::reg_idx_t       rd_idx,
  input  bft_cnfg_pkg::cmd_word_u      open_con_cmd_tdata,
  input  logic [31:0]                  open_port_cmd_tdata,
  input  logic [31:0]                  close_con_cmd_tdata,
  input  bft_cnfg_pkg::cnfg_word_t     max_pkg_word,
  input  bft_cnfg_pkg::cnfg_word_t     batch_max_timer,
  input  bft_cnfg_pkg::conn_sts_t      conn_sts_tdata,
  input  logic                         conn_sts_tvalid,
  input  logic [31:0]                  port_sts_tdata,
  input  logic                         port_sts_tvalid,
  input  bft_cnfg_pkg::byte_counters_t byte_counters,
  output bft_cnfg_pkg::cnfg_word_t     rdata,
  output logic                         conn_sts_tready,
  output logic                         port_sts_tready
);
  import bft_cnfg_pkg::*;

  conn_sts_rd_t conn_rd; // status squeezed into one bus word

  assign conn_rd = '{port:    conn_sts_tdata.port,
                     ip:      conn_sts_tdata.ip,
                     success: conn_sts_tdata.success[0],
                     session: conn_sts_tdata.session[14:0]};

  // ------------------------------
  // read mux and stream pops
  // ------------------------------
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      rdata           <= '0;
      conn_sts_tready <= 1'b0;
      port_sts_tready <= 1'b0;
    end else begin
      conn_sts_tready <= 1'b0;
      port_sts_tready <= 1'b0;
      if (rd_valid) begin
        case (rd_idx)
          `CNFG_REG_OPEN_CON:  rdata <= open_con_cmd_tdata.word;
          `CNFG_REG_OPEN_PORT: rdata <= cnfg_word_t'(open_port_cmd_tdata);
          `CNFG_REG_CLOSE_CON: rdata <= cnfg_word_t'(close_con_cmd_tdata);
          `CNFG_REG_OPEN_STATUS: begin
            rdata           <= conn_sts_tvalid ? cnfg_word_t'(conn_rd) : '0;
            conn_sts_tready <= conn_sts_tvalid; // pop only a real word
          end
          `CNFG_REG_PORT_STATUS: begin
            rdata           <= port_sts_tvalid ? cnfg_word_t'(port_sts_tdata) : '0;
            port_sts_tready <= port_sts_tvalid;
          end
          `CNFG_REG_CONS_BYTES_NET:  rdata <= byte_counters.cons_bytes_net;
          `CNFG_REG_PROD_BYTES_NET:  rdata <= byte_counters.prod_bytes_net;
          `CNFG_REG_CONS_BYTES_HOST: rdata <= byte_counters.cons_bytes_host;
          `CNFG_REG_PROD_BYTES_HOST: rdata <= byte_counters.prod_bytes_host;
          `CNFG_REG_MAX_PKG_WORD:    rdata <= max_pkg_word;
          `CNFG_REG_BATCH_MAX_TIMER: rdata <= batch_max_timer;
          default:                   rdata <= '0; // control and holes
        endcase
      end
    end
  end

  a_conn_pop: assert property (@(posedge aclk) disable iff (!aresetn)
    conn_sts_tready |-> $past(conn_sts_tvalid))
    else $error("conn status popped without valid");

  a_port_pop: assert property (@(posedge aclk) disable iff (!aresetn)
    port_sts_tready |-> $past(port_sts_tvalid))
    else $error("port status popped without valid");

endmodule

`default_nettype wire

//--- rtl/bft_cnfg_slave.sv
`timescale 1ns/1ps
`default_nettype none

module bft_cnfg_slave (
  input  logic                         aclk,
  input  logic                         aresetn,
  input  bft_cnfg_pkg::axil_req_t      axil_req,
  output bft_cnfg_pkg::axil_rsp_t      axil_rsp,
  output logic                         ap_clr,
  output bft_cnfg_pkg::cmd_word_u      open_con_cmd_tdata,
  output logic                         open_con_cmd_tvalid,
  output logic [31:0]                  open_port_cmd_tdata,
  output logic                         open_port_cmd_tvalid,
  output logic [31:0]                  close_con_cmd_tdata,
  output logic                         close_con_cmd_tvalid,
  output bft_cnfg_pkg::cmd_word_u      buff_cmd_tdata,
  output logic                         buff_cmd_tvalid,
  input  bft_cnfg_pkg::conn_sts_t      conn_sts_tdata,
  input  logic                         conn_sts_tvalid,
  output logic                         conn_sts_tready,
  input  logic [31:0]                  port_sts_tdata,
  input  logic                         port_sts_tvalid,
  output logic                         port_sts_tready,
  input  bft_cnfg_pkg::byte_counters_t byte_counters,
  output bft_cnfg_pkg::cnfg_word_t     max_pkg_word,
  output bft_cnfg_pkg::cnfg_word_t     batch_max_timer
);
  import bft_cnfg_pkg::*;

  logic       awready, wready, bvalid, wr_valid;
  logic       arready, rvalid, rd_valid;
  wr_req_t    wr_req;
  reg_idx_t   rd_idx;
  cnfg_word_t rdata;

  axil_wr_channel wr_ch0 (.aclk, .aresetn, .axil_req, .awready, .wready, .bvalid,
                          .wr_valid, .wr_req);

  axil_rd_channel rd_ch0 (.aclk, .aresetn, .axil_req, .arready, .rvalid, .rd_valid,
                          .rd_idx);

  cnfg_reg_file regs0 (.aclk, .aresetn, .wr_valid, .wr_req, .ap_clr,
                       .open_con_cmd_tdata, .open_con_cmd_tvalid,
                       .open_port_cmd_tdata, .open_port_cmd_tvalid,
                       .close_con_cmd_tdata, .close_con_cmd_tvalid,
                       .buff_cmd_tdata, .buff_cmd_tvalid, .max_pkg_word, .batch_max_timer);

  cnfg_status_reader rd0 (.aclk, .aresetn, .rd_valid, .rd_idx, .open_con_cmd_tdata,
                          .open_port_cmd_tdata, .close_con_cmd_tdata, .max_pkg_word,
                          .batch_max_timer, .conn_sts_tdata, .conn_sts_tvalid,
                          .port_sts_tdata, .port_sts_tvalid, .byte_counters, .rdata,
                          .conn_sts_tready, .port_sts_tready);

  // responses are always OKAY
  always_comb begin
    axil_rsp         = '0;
    axil_rsp.awready = awready;
    axil_rsp.wready  = wready;
    axil_rsp.bvalid  = bvalid;
    axil_rsp.bresp   = 2'b00;
    axil_rsp.arready = arready;
    axil_rsp.rvalid  = rvalid;
    axil_rsp.rdata   = rdata;
    axil_rsp.rresp   = 2'b00;
  end

endmodule

`default_nettype wire

//--- verif/tb_bft_cnfg_slave.sv
`timescale 1ns/1ps
`default_nettype none

`include "bft_cnfg_config.svh"

module tb_bft_cnfg_slave;
  import bft_cnfg_pkg::*;

  localparam int CLK_PERIOD      = 20;
  localparam int N_TRANS         = 27;                 // 9 writes and 18 reads below
  localparam int WATCHDOG_CYCLES = N_TRANS * 200 + 16;

  logic           aclk = 1'b0;
  logic           aresetn;
  axil_req_t      axil_req;
  axil_rsp_t      axil_rsp;
  logic           ap_clr;
  cmd_word_u      open_con_cmd_tdata, buff_cmd_tdata;
  logic [31:0]    open_port_cmd_tdata, close_con_cmd_tdata;
  logic           open_con_cmd_tvalid, open_port_cmd_tvalid;
  logic           close_con_cmd_tvalid, buff_cmd_tvalid;
  conn_sts_t      conn_sts_tdata;
  logic           conn_sts_tvalid, conn_sts_tready;
  logic [31:0]    port_sts_tdata;
  logic           port_sts_tvalid, port_sts_tready;
  byte_counters_t byte_counters;
  cnfg_word_t     max_pkg_word, batch_max_timer;

  int               seed   = 32'h72bc;
  int               errors = 0;
  int               checks = 0;
  cnfg_word_t       model [`CNFG_N_REGS]; // expected register contents
  int               cmd_pulses [4];
  cnfg_word_t       cmd_seen [4];         // tdata at the last pulse
  int               clr_pulses, conn_pops, port_pops;
  string            cmd_names [4] = '{"open_con_cmd", "open_port_cmd", "close_con_cmd",
                                      "buff_cmd"};
  logic [3:0]       cmd_valids;
  cnfg_word_t [3:0] cmd_datas;

  assign cmd_valids = {buff_cmd_tvalid, close_con_cmd_tvalid, open_port_cmd_tvalid,
                       open_con_cmd_tvalid};
  assign cmd_datas  = {buff_cmd_tdata.word, {32'h0, close_con_cmd_tdata},
                       {32'h0, open_port_cmd_tdata}, open_con_cmd_tdata.word};

  bft_cnfg_slave dut0 (
    .aclk, .aresetn, .axil_req, .axil_rsp, .ap_clr,
    .open_con_cmd_tdata, .open_con_cmd_tvalid, .open_port_cmd_tdata, .open_port_cmd_tvalid,
    .close_con_cmd_tdata, .close_con_cmd_tvalid, .buff_cmd_tdata, .buff_cmd_tvalid,
    .conn_sts_tdata, .conn_sts_tvalid, .conn_sts_tready,
    .port_sts_tdata, .port_sts_tvalid, .port_sts_tready,
    .byte_counters, .max_pkg_word, .batch_max_timer
  );

  always #(CLK_PERIOD / 2) aclk = ~aclk;

  // ------------------------------
  // reference rules
  // ------------------------------
  function automatic cnfg_word_t rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic cnfg_word_t apply_strobes(input cnfg_word_t cur, input cnfg_word_t wdata,
                                               input logic [7:0] strb);
    cnfg_word_t mask;
    for (int b = 0; b < 8; b++) begin
      mask[8*b +: 8] = {8{strb[b]}};
    end
    return (cur & ~mask) | (wdata & mask);
  endfunction

  // port, ip, success bit 0, session low 15 bits
  function automatic cnfg_word_t conn_status_word(input conn_sts_t sts);
    return {sts.port, sts.ip, sts.success[0], sts.session[14:0]};
  endfunction

  function automatic cnfg_word_t expected_read(input reg_idx_t idx);
    case (idx)
      `CNFG_REG_OPEN_PORT, `CNFG_REG_CLOSE_CON: return {32'h0, model[idx][31:0]};
      `CNFG_REG_CONS_BYTES_NET:  return byte_counters.cons_bytes_net;
      `CNFG_REG_PROD_BYTES_NET:  return byte_counters.prod_bytes_net;
      `CNFG_REG_CONS_BYTES_HOST: return byte_counters.cons_bytes_host;
      `CNFG_REG_PROD_BYTES_HOST: return byte_counters.prod_bytes_host;
      default:                   return model[idx]; // holes stay zero
    endcase
  endfunction

  task automatic check_word(input string name, input cnfg_word_t got, input cnfg_word_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic clear_pulse_counts();
    for (int i = 0; i < 4; i++) begin
      cmd_pulses[i] = 0;
    end
    clr_pulses = 0;
    conn_pops  = 0;
    port_pops  = 0;
  endtask

  // which < 0 means no command may pulse
  task automatic expect_cmd(input int which, input cnfg_word_t exp_data);
    for (int i = 0; i < 4; i++) begin
      check_word({cmd_names[i], "_tvalid pulses"}, cmd_pulses[i], (i == which) ? 1 : 0);
    end
    if (which >= 0) begin
      check_word({cmd_names[which], "_tdata"}, cmd_seen[which], exp_data);
    end
  endtask

  // ------------------------------
  // bus transactions
  // ------------------------------
  task automatic write_reg(input reg_idx_t idx, input cnfg_word_t data, input logic [7:0] strb);
    clear_pulse_counts();
    if (idx != `CNFG_REG_CONTROL) begin
      model[idx] = apply_strobes(model[idx], data, strb); // control is write only
    end
    @(posedge aclk);
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= {idx, 3'b000};
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= strb;
    @(negedge aclk);
    while (!(axil_rsp.awready && axil_rsp.wready)) @(negedge aclk);
    @(posedge aclk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    @(negedge aclk);
    while (!axil_rsp.bvalid) @(negedge aclk);
    check_word("bresp", axil_rsp.bresp, 64'h0);
    repeat (2) @(posedge aclk);  // bvalid has to wait for bready
    axil_req.bready <= 1'b1;
    @(posedge aclk);
    axil_req.bready <= 1'b0;
  endtask

  task automatic read_check(input reg_idx_t idx, input string name, input cnfg_word_t exp);
    cnfg_word_t rd;
    clear_pulse_counts();
    @(posedge aclk);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= {idx, 3'b000};
    @(negedge aclk);
    while (!axil_rsp.arready) @(negedge aclk);
    @(posedge aclk);
    axil_req.arvalid <= 1'b0;
    @(negedge aclk);
    while (!axil_rsp.rvalid) @(negedge aclk);
    rd = axil_rsp.rdata;
    check_word("rresp", axil_rsp.rresp, 64'h0);
    repeat (2) @(posedge aclk);  // rvalid held until rready
    axil_req.rready <= 1'b1;
    @(posedge aclk);
    axil_req.rready <= 1'b0;
    check_word(name, rd, exp);
  endtask

  // second address stays on the bus while the first response is pending
  task automatic read_pair(input reg_idx_t idx_a, input string name_a,
                           input cnfg_word_t exp_a, input reg_idx_t idx_b,
                           input string name_b, input cnfg_word_t exp_b);
    cnfg_word_t rd_a;
    cnfg_word_t rd_b;
    clear_pulse_counts();
    @(posedge aclk);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= {idx_a, 3'b000};
    @(negedge aclk);
    while (!axil_rsp.arready) @(negedge aclk);
    @(posedge aclk);
    axil_req.araddr <= {idx_b, 3'b000}; // arvalid kept high
    @(negedge aclk);
    while (!axil_rsp.rvalid) @(negedge aclk);
    rd_a = axil_rsp.rdata;
    check_word("rresp", axil_rsp.rresp, 64'h0);
    repeat (2) @(posedge aclk);
    axil_req.rready <= 1'b1;
    @(posedge aclk);
    axil_req.rready <= 1'b0;
    @(negedge aclk);
    while (!axil_rsp.arready) @(negedge aclk);
    @(posedge aclk);
    axil_req.arvalid <= 1'b0;
    @(negedge aclk);
    while (!axil_rsp.rvalid) @(negedge aclk);
    rd_b = axil_rsp.rdata;
    check_word("rresp", axil_rsp.rresp, 64'h0);
    repeat (2) @(posedge aclk);
    axil_req.rready <= 1'b1;
    @(posedge aclk);
    axil_req.rready <= 1'b0;
    check_word(name_a, rd_a, exp_a);
    check_word(name_b, rd_b, exp_b);
  endtask

  always @(negedge aclk) begin
    if (aresetn) begin
      for (int i = 0; i < 4; i++) begin
        if (cmd_valids[i]) begin
          cmd_pulses[i]++;
          cmd_seen[i] = cmd_datas[i];
        end
      end
      clr_pulses += int'(ap_clr);
      conn_pops  += int'(conn_sts_tready);
      port_pops  += int'(port_sts_tready);
    end
  end

  // ------------------------------
  // protocol properties
  // ------------------------------
  a_cmd_single: assert property (@(posedge aclk) disable iff (!aresetn)
    (|cmd_valids) |=> !(|cmd_valids))
    else begin
      errors++;
      $display("%0t: a command tvalid stayed high longer than one cycle", $time);
    end

  a_clr_single: assert property (@(posedge aclk) disable iff (!aresetn)
    ap_clr |=> !ap_clr)
    else begin
      errors++;
      $display("%0t: ap_clr stayed high longer than one cycle", $time);
    end

  a_r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
    else begin
      errors++;
      $display("%0t: read response changed or dropped before rready", $time);
    end

  a_b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else begin
      errors++;
      $display("%0t: bvalid dropped before bready", $time);
    end

  a_ar_blocked: assert property (@(posedge aclk) disable iff (!aresetn)
    !(axil_rsp.rvalid && axil_rsp.arready))
    else begin
      errors++;
      $display("%0t: arready high while a read response was pending", $time);
    end

  a_conn_pop: assert property (@(posedge aclk) disable iff (!aresetn)
    conn_sts_tready |-> conn_sts_tvalid && $rose(axil_rsp.rvalid))
    else begin
      errors++;
      $display("%0t: conn_sts_tready pulsed without a valid word or read", $time);
    end

  a_port_pop: assert property (@(posedge aclk) disable iff (!aresetn)
    port_sts_tready |-> port_sts_tvalid && $rose(axil_rsp.rvalid))
    else begin
      errors++;
      $display("%0t: port_sts_tready pulsed without a valid word or read", $time);
    end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout after %0d cycles, a bus handshake never completed", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    conn_sts_t   sts;
    logic [31:0] psts;
    cnfg_word_t  w;
    aresetn         = 1'b0;
    axil_req        = '0;
    conn_sts_tdata  = '0;
    conn_sts_tvalid = 1'b0;
    port_sts_tdata  = '0;
    port_sts_tvalid = 1'b0;
    byte_counters   = {rand64(), rand64(), rand64(), rand64()};
    foreach (model[i]) model[i] = '0;
    clear_pulse_counts();
    repeat (16) @(posedge aclk);
    aresetn <= 1'b1;
    @(negedge aclk);
    check_word("cmd tvalids", cmd_valids, 64'h0);
    check_word("status treadies", {conn_sts_tready, port_sts_tready}, 64'h0);
    check_word("ap_clr", ap_clr, 64'h0);
    check_word("bvalid", axil_rsp.bvalid, 64'h0);
    check_word("rvalid", axil_rsp.rvalid, 64'h0);

    w = rand64();
    write_reg(`CNFG_REG_OPEN_CON, w, 8'hff);
    expect_cmd(0, w);
    write_reg(`CNFG_REG_OPEN_CON, rand64(), 8'h5a);  // bytes 1, 3, 4 and 6
    expect_cmd(0, model[`CNFG_REG_OPEN_CON]);
    read_check(`CNFG_REG_OPEN_CON, "open_con rdata", expected_read(`CNFG_REG_OPEN_CON));
    write_reg(`CNFG_REG_OPEN_CON, rand64(), 8'h00);
    expect_cmd(-1, 64'h0);
    read_check(`CNFG_REG_OPEN_CON, "open_con rdata", expected_read(`CNFG_REG_OPEN_CON));

    w = rand64();
    write_reg(`CNFG_REG_OPEN_PORT, w, 8'hff);
    expect_cmd(1, {32'h0, w[31:0]});
    read_check(`CNFG_REG_OPEN_PORT, "open_port rdata", expected_read(`CNFG_REG_OPEN_PORT));
    w = rand64();
    write_reg(`CNFG_REG_CLOSE_CON, w, 8'hff);
    expect_cmd(2, {32'h0, w[31:0]});
    read_check(`CNFG_REG_CLOSE_CON, "close_con rdata", expected_read(`CNFG_REG_CLOSE_CON));
    w = rand64();
    write_reg(`CNFG_REG_BUFF_CMD, w, 8'hff);
    expect_cmd(3, w);

    write_reg(`CNFG_REG_MAX_PKG_WORD, rand64(), 8'hff);
    expect_cmd(-1, 64'h0);
    check_word("max_pkg_word", max_pkg_word, model[`CNFG_REG_MAX_PKG_WORD]);
    read_check(`CNFG_REG_MAX_PKG_WORD, "max_pkg_word rdata",
               expected_read(`CNFG_REG_MAX_PKG_WORD));
    write_reg(`CNFG_REG_BATCH_MAX_TIMER, rand64(), 8'hff);
    check_word("batch_max_timer", batch_max_timer, model[`CNFG_REG_BATCH_MAX_TIMER]);
    read_check(`CNFG_REG_BATCH_MAX_TIMER, "batch_max_timer rdata",
               expected_read(`CNFG_REG_BATCH_MAX_TIMER));

    write_reg(`CNFG_REG_CONTROL, 64'h1, 8'h01);
    check_word("ap_clr high cycles", clr_pulses, 1);

    // status streams, one word present then none
    sts = {rand64(), rand64()};
    @(posedge aclk);
    conn_sts_tdata  <= sts;
    conn_sts_tvalid <= 1'b1;
    read_check(`CNFG_REG_OPEN_STATUS, "open status rdata", conn_status_word(sts));
    check_word("conn_sts_tready pulses", conn_pops, 1);
    conn_sts_tvalid <= 1'b0;
    read_check(`CNFG_REG_OPEN_STATUS, "empty open status rdata", 64'h0);
    check_word("conn_sts_tready pulses", conn_pops, 0);
    psts = $random(seed);
    @(posedge aclk);
    port_sts_tdata  <= psts;
    port_sts_tvalid <= 1'b1;
    read_check(`CNFG_REG_PORT_STATUS, "port status rdata", {32'h0, psts});
    check_word("port_sts_tready pulses", port_pops, 1);
    port_sts_tvalid <= 1'b0;
    read_check(`CNFG_REG_PORT_STATUS, "empty port status rdata", 64'h0);
    check_word("port_sts_tready pulses", port_pops, 0);

    read_pair(`CNFG_REG_CONS_BYTES_NET, "cons_bytes_net", expected_read(5'd7),
              `CNFG_REG_PROD_BYTES_NET, "prod_bytes_net", expected_read(5'd8));
    read_check(`CNFG_REG_CONS_BYTES_HOST, "cons_bytes_host", expected_read(5'd12));
    read_check(`CNFG_REG_PROD_BYTES_HOST, "prod_bytes_host", expected_read(5'd13));
    read_check(`CNFG_REG_CONTROL, "control rdata", 64'h0);
    read_check(5'd1, "unmapped rdata", 64'h0);
    read_check(5'd9, "unmapped rdata", 64'h0);
    read_check(5'd20, "unmapped rdata", 64'h0);

    repeat (4) @(posedge aclk);
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
rtl/bft_cnfg_pkg.sv
rtl/axil_wr_channel.sv
rtl/axil_rd_channel.sv
rtl/cnfg_reg_file.sv
rtl/cnfg_status_reader.sv
rtl/bft_cnfg_slave.sv
verif/tb_bft_cnfg_slave.sv

//--- Bender.yml
package:
  name: bft_cnfg_slave

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/bft_cnfg_pkg.sv
      - rtl/axil_wr_channel.sv
      - rtl/axil_rd_channel.sv
      - rtl/cnfg_reg_file.sv
      - rtl/cnfg_status_reader.sv
      - rtl/bft_cnfg_slave.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_bft_cnfg_slave.sv
